/* all.f */
hdl/wb_bus_pkg.sv
hdl/wb_if.sv
hdl/wb_arbiter.sv
hdl/wb_master_mux.sv
hdl/wb_slave_sel.sv
hdl/wb_ram_slave.sv
hdl/wb_sg_bus.sv
tb/wb_bus_checker.sv
tb/wb_bus_monitor.sv
tb/tb_wb_sg_bus.sv

/* hdl/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
   input  logic                               wb_clk_i,
   input  logic                               wb_rst_i,
   input  logic [wb_bus_pkg::num_masters-1:0] cyc,    // Request level per master
   output wb_bus_pkg::grant_t                 gnt     // Registered one-hot grant
);

   wb_bus_pkg::arb_state_t state;     // Current owner
   wb_bus_pkg::arb_state_t state_n;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         state <= wb_bus_pkg::owner0;   // Master 0 holds the bus out of reset
      else
         state <= state_n;
   end

   // Rotating search, starts at the master after the owner
   // Nothing moves while the owner keeps cyc high
   always_comb begin
      state_n = state;
      case (state)
         wb_bus_pkg::owner0: begin
            if (!cyc[0]) begin
               if (cyc[1])      state_n = wb_bus_pkg::owner1;
               else if (cyc[2]) state_n = wb_bus_pkg::owner2;
               else if (cyc[3]) state_n = wb_bus_pkg::owner3;
               else if (cyc[4]) state_n = wb_bus_pkg::owner4;
            end
         end
         wb_bus_pkg::owner1: begin
            if (!cyc[1]) begin
               if (cyc[2])      state_n = wb_bus_pkg::owner2;
               else if (cyc[3]) state_n = wb_bus_pkg::owner3;
               else if (cyc[4]) state_n = wb_bus_pkg::owner4;
               else if (cyc[0]) state_n = wb_bus_pkg::owner0;   // Wrap around
            end
         end
         wb_bus_pkg::owner2: begin
            if (!cyc[2]) begin
               if (cyc[3])      state_n = wb_bus_pkg::owner3;
               else if (cyc[4]) state_n = wb_bus_pkg::owner4;
               else if (cyc[0]) state_n = wb_bus_pkg::owner0;
               else if (cyc[1]) state_n = wb_bus_pkg::owner1;
            end
         end
         wb_bus_pkg::owner3: begin
            if (!cyc[3]) begin
               if (cyc[4])      state_n = wb_bus_pkg::owner4;
               else if (cyc[0]) state_n = wb_bus_pkg::owner0;
               else if (cyc[1]) state_n = wb_bus_pkg::owner1;
               else if (cyc[2]) state_n = wb_bus_pkg::owner2;
            end
         end
         wb_bus_pkg::owner4: begin
            if (!cyc[4]) begin
               if (cyc[0])      state_n = wb_bus_pkg::owner0;
               else if (cyc[1]) state_n = wb_bus_pkg::owner1;
               else if (cyc[2]) state_n = wb_bus_pkg::owner2;
               else if (cyc[3]) state_n = wb_bus_pkg::owner3;
            end
         end
         default: state_n = wb_bus_pkg::owner0;   // Recover from a corrupt state
      endcase
   end

   // State encoding is already one-hot
   assign gnt = wb_bus_pkg::grant_t'(state);

endmodule

/* hdl/wb_bus_pkg.sv */
package wb_bus_pkg;

   // Bus dimensions
   localparam int num_masters    = 5;    // DMA channels sharing the bus
   localparam int num_slaves     = 2;    // On-chip RAM banks
   localparam int adr_w          = 32;   // Byte address
   localparam int dat_w          = 32;   // Word data
   localparam int sel_w          = 4;    // One select per byte lane
   localparam int byte_off_w     = 2;    // Byte offset bits below the word index
   localparam int ram_depth_log2 = 8;    // 256 words per bank
   localparam int bank_bit       = 10;   // Just above the word index

   typedef logic [adr_w-1:0]          wb_adr_t;
   typedef logic [dat_w-1:0]          wb_dat_t;
   typedef logic [sel_w-1:0]          wb_sel_t;
   typedef logic [num_masters-1:0]    grant_t;     // One-hot, bit i owns the bus
   typedef logic [ram_depth_log2-1:0] ram_idx_t;

   // Arbiter owner, one-hot so the state doubles as the grant
   typedef enum logic [num_masters-1:0] {
      owner0 = 5'b00001,
      owner1 = 5'b00010,
      owner2 = 5'b00100,
      owner3 = 5'b01000,
      owner4 = 5'b10000
   } arb_state_t;

   // Bank decode
   function automatic logic bank_of(input wb_adr_t adr);
      return adr[bank_bit];
   endfunction

   // Word index inside a bank, byte offset dropped
   function automatic ram_idx_t word_idx(input wb_adr_t adr);
      return adr[byte_off_w +: ram_depth_log2];
   endfunction

endpackage

/* hdl/wb_if.sv */
`timescale 1ns/1ps

// Classic Wishbone signal set, no tags or stall
interface wb_if;

   logic                cyc;     // Bus ownership
   logic                stb;     // Valid transfer
   logic                we;      // 1 = write
   wb_bus_pkg::wb_adr_t adr;
   wb_bus_pkg::wb_dat_t dat_w;   // Master to slave
   wb_bus_pkg::wb_sel_t sel;     // Byte lanes
   wb_bus_pkg::wb_dat_t dat_r;   // Slave to master
   logic                ack;     // One cycle per strobe

   modport master (
      output cyc,
      output stb,
      output we,
      output adr,
      output dat_w,
      output sel,
      input  dat_r,
      input  ack
   );

   // Mirror of the master side
   modport slave (
      input  cyc,
      input  stb,
      input  we,
      input  adr,
      input  dat_w,
      input  sel,
      output dat_r,
      output ack
   );

endinterface

/* hdl/wb_master_mux.sv */
`timescale 1ns/1ps

module wb_master_mux (
   input  wb_bus_pkg::grant_t                                gnt,
   input  logic [wb_bus_pkg::num_masters-1:0]                m_cyc,
   input  logic [wb_bus_pkg::num_masters-1:0]                m_stb,
   input  logic [wb_bus_pkg::num_masters-1:0]                m_we,
   input  wb_bus_pkg::wb_adr_t [wb_bus_pkg::num_masters-1:0] m_adr,
   input  wb_bus_pkg::wb_dat_t [wb_bus_pkg::num_masters-1:0] m_dat_w,
   input  wb_bus_pkg::wb_sel_t [wb_bus_pkg::num_masters-1:0] m_sel,
   output logic [wb_bus_pkg::num_masters-1:0]                m_ack,
   output wb_bus_pkg::wb_dat_t                               m_dat_r,
   wb_if.master                                              bus      // Shared bus
);

   wb_bus_pkg::wb_adr_t adr_or;   // Granted master's address
   wb_bus_pkg::wb_dat_t dat_or;   // Granted master's write data
   wb_bus_pkg::wb_sel_t sel_or;   // Granted master's byte lanes

   // AND-OR select, grant is one-hot so only one term survives
   always_comb begin
      adr_or = '0;
      dat_or = '0;
      sel_or = '0;
      for (int i = 0; i < wb_bus_pkg::num_masters; i++) begin
         adr_or = adr_or | (m_adr[i]   & {wb_bus_pkg::adr_w{gnt[i]}});
         dat_or = dat_or | (m_dat_w[i] & {wb_bus_pkg::dat_w{gnt[i]}});
         sel_or = sel_or | (m_sel[i]   & {wb_bus_pkg::sel_w{gnt[i]}});
      end
   end

   // Single-bit controls reduce straight from the masked vectors
   assign bus.cyc   = |(m_cyc & gnt);
   assign bus.stb   = |(m_stb & gnt);    // Waiting masters never reach the bus
   assign bus.we    = |(m_we  & gnt);
   assign bus.adr   = adr_or;
   assign bus.dat_w = dat_or;
   assign bus.sel   = sel_or;

   // Ack steered back to the owner only
   assign m_ack   = gnt & {wb_bus_pkg::num_masters{bus.ack}};
   assign m_dat_r = bus.dat_r;           // Broadcast, qualified by m_ack

endmodule

/* hdl/wb_ram_slave.sv */
`timescale 1ns/1ps

module wb_ram_slave (
   input  logic wb_clk_i,
   input  logic wb_rst_i,
   wb_if.slave  wb
);

   localparam int depth = 2 ** wb_bus_pkg::ram_depth_log2;

   wb_bus_pkg::wb_dat_t  mem [0:depth-1];   // Word storage
   wb_bus_pkg::ram_idx_t idx;               // Word within this bank
   wb_bus_pkg::wb_dat_t  rd_q;              // Registered read data
   logic                 ack_q;
   logic                 access;            // New strobe seen this cycle

   assign idx = wb_bus_pkg::word_idx(wb.adr);

   // The ~ack_q term gives the wait state and keeps ack to one cycle
   assign access = wb.cyc & wb.stb & ~ack_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i)
         ack_q <= 1'b0;
      else
         ack_q <= access;           // High for exactly one cycle per strobe
   end

   // Write lands on the same edge that raises ack
   always_ff @(posedge wb_clk_i) begin
      if (access && wb.we) begin
         for (int b = 0; b < wb_bus_pkg::sel_w; b++) begin
            if (wb.sel[b])
               mem[idx][8*b +: 8] <= wb.dat_w[8*b +: 8];   // Byte lane b
         end
      end
   end

   // Read captured with the ack, valid while ack is high
   always_ff @(posedge wb_clk_i) begin
      if (access)
         rd_q <= mem[idx];
   end

   assign wb.ack   = ack_q;
   assign wb.dat_r = rd_q;

endmodule

/* hdl/wb_sg_bus.sv */
`timescale 1ns/1ps

module wb_sg_bus (
   input  logic                                              wb_clk_i,
   input  logic                                              wb_rst_i,
   // Master side, one entry per DMA channel
   input  logic [wb_bus_pkg::num_masters-1:0]                m_cyc,
   input  logic [wb_bus_pkg::num_masters-1:0]                m_stb,
   input  logic [wb_bus_pkg::num_masters-1:0]                m_we,
   input  wb_bus_pkg::wb_adr_t [wb_bus_pkg::num_masters-1:0] m_adr,
   input  wb_bus_pkg::wb_dat_t [wb_bus_pkg::num_masters-1:0] m_dat_w,
   input  wb_bus_pkg::wb_sel_t [wb_bus_pkg::num_masters-1:0] m_sel,
   output logic [wb_bus_pkg::num_masters-1:0]                m_ack,
   output wb_bus_pkg::wb_dat_t                               m_dat_r   // Valid with ack
);

   wb_bus_pkg::grant_t gnt;   // Current bus owner

   wb_if bus_if ();      // Shared bus after the master mux
   wb_if bank0_if ();    // Selector to bank 0
   wb_if bank1_if ();    // Selector to bank 1

   // Ownership follows the cyc levels only
   wb_arbiter u_arbiter (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cyc      (m_cyc),
      .gnt      (gnt)
   );

   wb_master_mux u_master_mux (
      .gnt     (gnt),
      .m_cyc   (m_cyc),
      .m_stb   (m_stb),
      .m_we    (m_we),
      .m_adr   (m_adr),
      .m_dat_w (m_dat_w),
      .m_sel   (m_sel),
      .m_ack   (m_ack),
      .m_dat_r (m_dat_r),
      .bus     (bus_if.master)
   );

   wb_slave_sel u_slave_sel (
      .bus   (bus_if.slave),
      .bank0 (bank0_if.master),
      .bank1 (bank1_if.master)
   );

   // Two identical banks, split on the bank address bit
   wb_ram_slave u_bank0 (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb       (bank0_if.slave)
   );

   wb_ram_slave u_bank1 (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb       (bank1_if.slave)
   );

endmodule

/* hdl/wb_slave_sel.sv */
`timescale 1ns/1ps

module wb_slave_sel (
   wb_if.slave  bus,     // From the master mux
   wb_if.master bank0,   // Bank bit clear
   wb_if.master bank1    // Bank bit set
);

   logic                                    bank_sel;   // Decoded bank number
   logic [wb_bus_pkg::num_slaves-1:0]       hit;        // One-hot bank select
   logic [wb_bus_pkg::num_slaves-1:0]       ack_vec;
   wb_bus_pkg::wb_dat_t                     rd_data;

   assign bank_sel = wb_bus_pkg::bank_of(bus.adr);
   assign hit      = bank_sel ? 2'b10 : 2'b01;

   // Request side, only stb is qualified by the decode
   assign bank0.cyc   = bus.cyc;
   assign bank0.stb   = bus.stb & hit[0];
   assign bank0.we    = bus.we;
   assign bank0.adr   = bus.adr;
   assign bank0.dat_w = bus.dat_w;
   assign bank0.sel   = bus.sel;

   assign bank1.cyc   = bus.cyc;
   assign bank1.stb   = bus.stb & hit[1];
   assign bank1.we    = bus.we;
   assign bank1.adr   = bus.adr;
   assign bank1.dat_w = bus.dat_w;
   assign bank1.sel   = bus.sel;

   // Response side
   // Address is held until ack, so the decode is still valid on the return path
   assign ack_vec = {bank1.ack, bank0.ack} & hit;

   always_comb begin
      if (hit[1])
         rd_data = bank1.dat_r;
      else
         rd_data = bank0.dat_r;
   end

   assign bus.ack   = |ack_vec;
   assign bus.dat_r = rd_data;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
set -o pipefail 2>/dev/null || true

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_wb_sg_bus -f all.f -o sim_wb_sg_bus

./obj_dir/sim_wb_sg_bus | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
   echo "simulation reported failure"
   exit 1
fi
exit 0

/* tb/tb_wb_sg_bus.sv */
`timescale 1ns/1ps

module tb_wb_sg_bus;

   localparam int nm      = wb_bus_pkg::num_masters;
   localparam int max_cyc = 300;   // Wait bound per transfer

   logic                                              wb_clk_i = 1'b0;
   logic                                              wb_rst_i = 1'b1;
   logic [nm-1:0]                                     m_cyc   = '0;
   logic [nm-1:0]                                     m_stb   = '0;
   logic [nm-1:0]                                     m_we    = '0;
   wb_bus_pkg::wb_adr_t [nm-1:0]                      m_adr   = '0;
   wb_bus_pkg::wb_dat_t [nm-1:0]                      m_dat_w = '0;
   wb_bus_pkg::wb_sel_t [nm-1:0]                      m_sel   = '0;
   logic [nm-1:0]                                     m_ack;
   wb_bus_pkg::wb_dat_t                               m_dat_r;

   // Request mailbox per master, req_cnt ahead of done_cnt means pending
   int                  req_cnt  [nm];
   int                  done_cnt [nm];
   logic                cmd_we   [nm];
   wb_bus_pkg::wb_adr_t cmd_adr  [nm];
   wb_bus_pkg::wb_dat_t cmd_dat  [nm];
   wb_bus_pkg::wb_sel_t cmd_sel  [nm];
   logic                cmd_hold [nm];   // Keep cyc after the ack

   always #10 wb_clk_i = ~wb_clk_i;

   wb_sg_bus uut (.*);

   wb_bus_monitor u_monitor (.*);

   initial begin
      for (int i = 0; i < nm; i++) begin
         req_cnt[i]  = 0;
         done_cnt[i] = 0;
      end
   end

   // Master drivers, a request may be raised while reset is still high
   for (genvar g = 0; g < nm; g++) begin : g_drv
      always @(posedge wb_clk_i) begin
         if (m_stb[g]) begin
            if (m_ack[g]) begin
               m_stb[g]    <= 1'b0;
               m_cyc[g]    <= cmd_hold[g];
               done_cnt[g] <= done_cnt[g] + 1;
            end
         end else if (req_cnt[g] != done_cnt[g]) begin
            m_cyc[g]   <= 1'b1;
            m_stb[g]   <= 1'b1;
            m_we[g]    <= cmd_we[g];
            m_adr[g]   <= cmd_adr[g];
            m_dat_w[g] <= cmd_dat[g];
            m_sel[g]   <= cmd_sel[g];
         end
      end
   end

   // Word address in either bank
   function automatic wb_bus_pkg::wb_adr_t rand_adr();
      return wb_bus_pkg::wb_adr_t'($urandom & 32'h0000_07fc);
   endfunction

   task automatic access(input int m, input logic we, input wb_bus_pkg::wb_adr_t adr,
                         input wb_bus_pkg::wb_dat_t dat, input wb_bus_pkg::wb_sel_t sel,
                         input logic hold);
      int n;
      @(posedge wb_clk_i);
      cmd_we[m]   <= we;
      cmd_adr[m]  <= adr;
      cmd_dat[m]  <= dat;
      cmd_sel[m]  <= sel;
      cmd_hold[m] <= hold;
      req_cnt[m]  <= req_cnt[m] + 1;
      for (n = 0; n < max_cyc; n++) begin
         @(posedge wb_clk_i);
         if (done_cnt[m] == req_cnt[m])
            break;
      end
      if (n == max_cyc)
         u_monitor.report_failure($sformatf("timeout, master %0d never got its ack", m));
   endtask

   task automatic contend(input int m);
      repeat ($urandom % 4) @(posedge wb_clk_i);
      access(m, 1'($urandom), rand_adr(), $urandom, 4'hf, 1'b0);
   endtask

   task automatic hold_burst(input int m, input int len);
      for (int k = 0; k < len; k++)
         access(m, 1'($urandom), rand_adr(), $urandom, 4'($urandom), k != len - 1);
   endtask

   initial begin
      wb_bus_pkg::wb_adr_t a;
      wb_bus_pkg::wb_dat_t d;
      int                  m;
      int                  h;
      void'($urandom(88877));
      // Master 0 strobes through reset, its ack may only follow the release
      fork
         access(0, 1'b0, rand_adr(), '0, 4'hf, 1'b0);
         begin
            repeat (16) @(posedge wb_clk_i);
            wb_rst_i <= 1'b0;
         end
      join
      repeat (20) @(posedge wb_clk_i);   // Idle bus, no acks expected
      u_monitor.end_test("reset_idle");

      for (int i = 0; i < nm; i++) begin
         repeat (4) begin
            a = rand_adr();
            d = $urandom;
            access(i, 1'b1, a, d, 4'hf, 1'b0);
            access(i, 1'b0, a, '0, 4'hf, 1'b0);
         end
      end
      u_monitor.end_test("single_master");

      repeat (8) begin
         m = $urandom % nm;
         a = rand_adr();
         access(m, 1'b1, a, $urandom, 4'hf, 1'b0);
         access(m, 1'b1, a, $urandom, 4'($urandom), 1'b0);   // Partial lanes
         access(m, 1'b0, a, '0, 4'hf, 1'b0);
      end
      u_monitor.end_test("byte_select");

      repeat (4) begin
         a = $urandom & 32'h0000_03fc;   // Bank bit clear
         d = $urandom;
         access(0, 1'b1, a, d, 4'hf, 1'b0);
         access(1, 1'b1, a | 32'h400, ~d, 4'hf, 1'b0);
         access(2, 1'b0, a, '0, 4'hf, 1'b0);
         access(3, 1'b0, a | 32'h400, '0, 4'hf, 1'b0);
      end
      u_monitor.end_test("bank_split");

      repeat (10) begin
         for (int i = 0; i < nm; i++) begin
            automatic int k = i;
            fork
               contend(k);
            join_none
         end
         wait fork;
      end
      u_monitor.end_test("round_robin");

      repeat (5) begin
         h = $urandom % nm;
         fork
            hold_burst(h, 2 + $urandom % 4);
            contend((h + 1) % nm);
            contend((h + 3) % nm);
         join
      end
      u_monitor.end_test("held_owner");

      u_monitor.summary();
      if (u_monitor.errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

/* tb/wb_bus_checker.sv */
`timescale 1ns/1ps

// Protocol properties on the top level, bound into wb_sg_bus
module wb_bus_checker (
   input logic                               wb_clk_i,
   input logic                               wb_rst_i,
   input logic [wb_bus_pkg::num_masters-1:0] m_cyc,
   input logic [wb_bus_pkg::num_masters-1:0] m_ack,
   input wb_bus_pkg::grant_t                 gnt
);

   // Exactly one owner at all times
   a_gnt_onehot: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $onehot(gnt))
      else $error("grant vector is not one-hot");

   a_ack_onehot0: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      $onehot0(m_ack))
      else $error("more than one master acknowledged");

   // Ack only while the master is in a cycle
   a_ack_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (m_ack & ~m_cyc) == '0)
      else $error("ack sent to a master without cyc");

   a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      m_ack != '0 |=> m_ack == '0)
      else $error("ack held high for two cycles");

   // Owner keeps the bus while cyc is held
   a_gnt_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (m_cyc & gnt) != '0 |=> gnt == $past(gnt))
      else $error("grant moved while owner held cyc");

endmodule

bind wb_sg_bus wb_bus_checker u_checker (
   .wb_clk_i (wb_clk_i),
   .wb_rst_i (wb_rst_i),
   .m_cyc    (m_cyc),
   .m_ack    (m_ack),
   .gnt      (gnt)
);

/* tb/wb_bus_monitor.sv */
`timescale 1ns/1ps

module wb_bus_monitor (
   input logic                                              wb_clk_i,
   input logic                                              wb_rst_i,
   input logic [wb_bus_pkg::num_masters-1:0]                m_cyc,
   input logic [wb_bus_pkg::num_masters-1:0]                m_stb,
   input logic [wb_bus_pkg::num_masters-1:0]                m_we,
   input wb_bus_pkg::wb_adr_t [wb_bus_pkg::num_masters-1:0] m_adr,
   input wb_bus_pkg::wb_dat_t [wb_bus_pkg::num_masters-1:0] m_dat_w,
   input wb_bus_pkg::wb_sel_t [wb_bus_pkg::num_masters-1:0] m_sel,
   input logic [wb_bus_pkg::num_masters-1:0]                m_ack,
   input wb_bus_pkg::wb_dat_t                               m_dat_r
);

   localparam int nm = wb_bus_pkg::num_masters;

   logic [31:0] model_mem [0:511];   // Both banks, bank bit on top
   logic [3:0]  known [0:511];       // Bytes written so far
   int          own = 0;             // Predicted owner
   int          lat [nm];            // Owner cycles with stb, per master
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          test_start = 0;      // Error count when the test began

   initial begin
      for (int i = 0; i < 512; i++)
         known[i] = 4'b0000;
      for (int i = 0; i < nm; i++)
         lat[i] = 0;
   end

   task automatic report_failure(input string what);
      errors++;
      $display("Error at %0t: %s", $time, what);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %-14s finished, %0d errors", tests, name, errors - test_start);
      test_start = errors;
   endtask

   task automatic summary();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
   endtask

   // One acknowledged transfer of master m
   task automatic check_ack(input int m);
      int          slot;
      logic [31:0] mask;
      slot = {m_adr[m][wb_bus_pkg::bank_bit], m_adr[m][2 +: 8]};   // Bank, word
      checks++;
      if (m != own)
         $display("Fail t=%0t m_ack owner: got %0d expected %0d", $time, m, own);
      if (m != own)
         errors++;
      if (!m_cyc[m] || !m_stb[m])
         report_failure($sformatf("master %0d acknowledged without a request", m));
      if (lat[m] + 1 != 2) begin
         errors++;
         $display("Fail t=%0t m_ack latency[%0d]: got %0d expected 2", $time, m, lat[m] + 1);
      end
      if (m_we[m]) begin
         for (int b = 0; b < 4; b++) begin
            if (m_sel[m][b]) begin
               model_mem[slot][8*b +: 8] = m_dat_w[m][8*b +: 8];
               known[slot][b] = 1'b1;
            end
         end
      end else begin
         mask = {{8{known[slot][3]}}, {8{known[slot][2]}},
                 {8{known[slot][1]}}, {8{known[slot][0]}}};   // Unwritten bytes ignored
         if (((m_dat_r ^ model_mem[slot]) & mask) != 32'h0) begin
            errors++;
            $display("Fail t=%0t m_dat_r: got %h expected %h", $time,
                     m_dat_r & mask, model_mem[slot] & mask);
         end
      end
      lat[m] = 0;
   endtask

   always @(posedge wb_clk_i) begin
      logic found;
      int   cand;
      if (wb_rst_i) begin
         if (m_ack !== '0)
            report_failure("ack raised during reset");
         own = 0;                     // Master 0 owns after reset
         for (int i = 0; i < nm; i++)
            lat[i] = 0;
      end else begin
         for (int i = 0; i < nm; i++) begin
            if (m_ack[i])
               check_ack(i);
            else if (own == i && m_cyc[i] && m_stb[i])
               lat[i]++;
         end
         // Rotation on release, first requester after the owner
         found = 1'b0;
         if (!m_cyc[own]) begin
            for (int k = 1; k < nm; k++) begin
               cand = (own + k) % nm;
               if (!found && m_cyc[cand]) begin
                  own   = cand;
                  found = 1'b1;
               end
            end
         end
      end
   end

endmodule
